/* Makefile */
# Verilator build and run of the MIPS core testbench
VERILATOR ?= verilator
TOP ?= tbMipsCore
FILELIST ?= compile.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timescale 1ns/1ps -j 0
FAIL_MSG ?= Simulation finished: FAIL
PASS_MSG ?= Simulation finished: PASS

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh)
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
	  echo "Failure reported in $(LOG)"; exit 1; \
	elif ! grep -qF "$(PASS_MSG)" $(LOG); then \
	  echo "No result line found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* compile.f */
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/mipsCore.sv
testbench/tbMipsCore.sv

/* testbench/tbMipsCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsConsts.svh"

module tbMipsCore;
  import isaPkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_CASES = 5;
  localparam int RUN_CYCLES = 80; // Per case once reset is released
  localparam int CASE_BUDGET = 90; // Cycles allowed per case with reset included

  typedef struct packed {
    word_t [11:0] prog; // Unused words stay zero and decode as bubbles
    logic stallMode; // Random stall pulses
    int count; // Stores expected
    addr_t [3:0] addr;
    word_t [3:0] data;
  } testCase_t;

  logic CLK;
  logic RST_X;
  logic stall;
  addr_t iAddr;
  word_t iData;
  addr_t dAddr;
  word_t dWData;
  word_t dRData;
  logic dWrite;
  logic dRead;

  word_t imem [1024]; // Whole 12-bit byte space in words
  word_t dmem [1024];
  word_t readReg; // Registered data port
  testCase_t progTable [NUM_CASES];
  addr_t gotAddr [$]; // Stores seen in order
  word_t gotData [$];
  int addrErrs = 0;
  int dataErrs = 0;
  int countErrs = 0;
  int flagErrs = 0;

  mipsCore i_mipsCore (
    .CLK(CLK),
    .RST_X(RST_X),
    .stall(stall),
    .iAddr(iAddr),
    .iData(iData),
    .dAddr(dAddr),
    .dWData(dWData),
    .dRData(dRData),
    .dWrite(dWrite),
    .dRead(dRead)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Both memories read zero while reset is low
  assign iData = RST_X ? imem[iAddr[`ADDR_W-1:2]] : '0; // Same-cycle fetch
  assign dRData = RST_X ? readReg : '0;

  always @(posedge CLK) begin
    if (!RST_X) begin
      for (int i = 0; i < 1024; i++) begin
        dmem[10'(i)] <= '0; // Fresh data memory per case
      end
      readReg <= '0;
    end else begin
      if (dWrite) begin
        dmem[dAddr[`ADDR_W-1:2]] <= dWData;
      end
      if (dRead) begin
        readReg <= dmem[dAddr[`ADDR_W-1:2]]; // Held until the next read
      end
    end
  end

  function automatic word_t addWord(regIdx_t rd, regIdx_t rs, regIdx_t rt);
    return {6'h00, rs, rt, rd, 5'h00, `FN_ADD};
  endfunction

  function automatic word_t addiWord(regIdx_t rt, regIdx_t rs, imm_t imm);
    return {`OP_ADDI, rs, rt, imm};
  endfunction

  function automatic word_t lwWord(regIdx_t rt, regIdx_t rs, imm_t imm);
    return {`OP_LW, rs, rt, imm};
  endfunction

  function automatic word_t swWord(regIdx_t rt, regIdx_t rs, imm_t imm);
    return {`OP_SW, rs, rt, imm};
  endfunction

  function automatic word_t beqWord(regIdx_t rs, regIdx_t rt, imm_t imm);
    return {`OP_BEQ, rs, rt, imm}; // Offset in words from PC plus 4
  endfunction

  function automatic word_t bneWord(regIdx_t rs, regIdx_t rt, imm_t imm);
    return {`OP_BNE, rs, rt, imm};
  endfunction

  task automatic expectStore(input int c, input addr_t a, input word_t d);
    int k;
    k = progTable[3'(c)].count;
    progTable[3'(c)].addr[2'(k)] = a;
    progTable[3'(c)].data[2'(k)] = d;
    progTable[3'(c)].count = k + 1;
  endtask

  task automatic buildTable();
    word_t halt;
    halt = beqWord(5'd0, 5'd0, 16'hffff); // Branch to self
    for (int c = 0; c < NUM_CASES; c++) begin
      progTable[3'(c)] = '0;
    end
    // Arithmetic with writes to r0 dropped
    progTable[0].prog[0] = addiWord(5'd1, 5'd0, 16'd5);
    progTable[0].prog[1] = addiWord(5'd2, 5'd0, 16'd7);
    progTable[0].prog[2] = addWord(5'd3, 5'd1, 5'd2); // r3 = 12
    progTable[0].prog[3] = addiWord(5'd0, 5'd1, 16'd9);
    progTable[0].prog[4] = addWord(5'd4, 5'd1, 5'd0); // r4 = 5 if r0 held
    progTable[0].prog[5] = swWord(5'd3, 5'd0, 16'h0010);
    progTable[0].prog[6] = swWord(5'd4, 5'd0, 16'h0014);
    progTable[0].prog[7] = addiWord(5'd5, 5'd3, 16'hfffe); // 12 - 2
    progTable[0].prog[8] = swWord(5'd5, 5'd0, 16'h001c);
    progTable[0].prog[9] = halt;
    expectStore(0, 12'h010, 32'd12);
    expectStore(0, 12'h014, 32'd5);
    expectStore(0, 12'h01c, 32'd10);
    // Forwarding from EX/MEM, WB and write-through
    progTable[1].prog[0] = addiWord(5'd1, 5'd0, 16'd3);
    progTable[1].prog[1] = addWord(5'd2, 5'd1, 5'd1); // 6
    progTable[1].prog[2] = addWord(5'd3, 5'd2, 5'd1); // 9
    progTable[1].prog[3] = swWord(5'd3, 5'd0, 16'h0040); // Data one back
    progTable[1].prog[4] = addiWord(5'd4, 5'd3, 16'd1); // 10
    progTable[1].prog[5] = addiWord(5'd6, 5'd0, 16'h0050);
    progTable[1].prog[6] = swWord(5'd4, 5'd6, 16'h0000); // Data two back
    progTable[1].prog[7] = addWord(5'd7, 5'd4, 5'd6); // 0x5a
    progTable[1].prog[8] = swWord(5'd7, 5'd6, 16'h0004);
    progTable[1].prog[9] = halt;
    expectStore(1, 12'h040, 32'd9);
    expectStore(1, 12'h050, 32'd10);
    expectStore(1, 12'h054, 32'h0000005a);
    // Load-use on an ALU source and on store data
    progTable[2].prog[0] = addiWord(5'd1, 5'd0, 16'h1234);
    progTable[2].prog[1] = swWord(5'd1, 5'd0, 16'h0060);
    progTable[2].prog[2] = addiWord(5'd2, 5'd0, 16'h0011);
    progTable[2].prog[3] = lwWord(5'd3, 5'd0, 16'h0060);
    progTable[2].prog[4] = addWord(5'd4, 5'd3, 5'd2); // Needs the bubble
    progTable[2].prog[5] = swWord(5'd4, 5'd0, 16'h0064);
    progTable[2].prog[6] = lwWord(5'd5, 5'd0, 16'h0064);
    progTable[2].prog[7] = swWord(5'd5, 5'd0, 16'h0068);
    progTable[2].prog[8] = halt;
    expectStore(2, 12'h060, 32'h00001234);
    expectStore(2, 12'h064, 32'h00001245);
    expectStore(2, 12'h068, 32'h00001245);
    // Taken and not-taken branches
    progTable[3].prog[0] = addiWord(5'd1, 5'd0, 16'd1);
    progTable[3].prog[1] = beqWord(5'd1, 5'd1, 16'd2); // Taken to word 4
    progTable[3].prog[2] = swWord(5'd1, 5'd0, 16'h0080);
    progTable[3].prog[3] = swWord(5'd1, 5'd0, 16'h0084);
    progTable[3].prog[4] = bneWord(5'd1, 5'd0, 16'd1); // Taken to word 6
    progTable[3].prog[5] = swWord(5'd1, 5'd0, 16'h0088);
    progTable[3].prog[6] = beqWord(5'd1, 5'd0, 16'd1); // Falls through
    progTable[3].prog[7] = swWord(5'd1, 5'd0, 16'h008c);
    progTable[3].prog[8] = addiWord(5'd2, 5'd1, 16'd41);
    progTable[3].prog[9] = bneWord(5'd2, 5'd2, 16'd1); // Falls through
    progTable[3].prog[10] = swWord(5'd2, 5'd0, 16'h0090);
    progTable[3].prog[11] = halt;
    expectStore(3, 12'h08c, 32'd1);
    expectStore(3, 12'h090, 32'd42);
    // Load-use program again under random stall
    progTable[4] = progTable[2];
    progTable[4].stallMode = 1'b1;
  endtask

  task automatic checkAddr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      addrErrs++;
      $display("ERR %0t: %s is 0x%03h, expected 0x%03h", $time, what, got, exp);
    end
  endtask

  task automatic checkWord(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      dataErrs++;
      $display("ERR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic checkCount(input int got, input int exp, input string what);
    if (got != exp) begin
      countErrs++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flagErrs++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkResetOutputs(input int c, input string phase);
    checkFlag(dWrite, 1'b0, $sformatf("case %0d dWrite %s", c, phase));
    checkFlag(dRead, 1'b0, $sformatf("case %0d dRead %s", c, phase));
    checkAddr(iAddr, 12'h000, $sformatf("case %0d iAddr %s", c, phase));
  endtask

  task automatic runCase(input int c);
    testCase_t tc;
    tc = progTable[3'(c)];
    @(negedge CLK);
    RST_X = 1'b0;
    stall = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      imem[10'(i)] = '0;
    end
    for (int k = 0; k < 12; k++) begin
      imem[10'(k)] = tc.prog[4'(k)];
    end
    gotAddr.delete();
    gotData.delete();
    repeat (3) begin
      @(negedge CLK);
      checkResetOutputs(c, "in reset");
    end
    RST_X = 1'b1;
    #1;
    checkResetOutputs(c, "after reset"); // First fetch still pending
    for (int n = 0; n < RUN_CYCLES; n++) begin
      @(negedge CLK);
      stall = tc.stallMode && (($urandom % 4) == 0); // About one cycle in four
      #1;
      if (dWrite === 1'b1) begin
        gotAddr.push_back(dAddr); // Written on the coming rising edge
        gotData.push_back(dWData);
      end
    end
    checkCount(gotAddr.size(), tc.count, $sformatf("case %0d store count", c));
    for (int k = 0; k < tc.count && k < gotAddr.size(); k++) begin
      checkAddr(gotAddr[k], tc.addr[2'(k)], $sformatf("case %0d store %0d address", c, k));
      checkWord(gotData[k], tc.data[2'(k)], $sformatf("case %0d store %0d data", c, k));
    end
  endtask

  initial begin
    int total;
    RST_X = 1'b0;
    stall = 1'b0;
    void'($urandom(32'hf2e5));
    buildTable();
    for (int c = 0; c < NUM_CASES; c++) begin
      runCase(c);
    end
    total = addrErrs + dataErrs + countErrs + flagErrs;
    $display("Errors: %0d address, %0d data, %0d count, %0d flag, %0d total",
      addrErrs, dataErrs, countErrs, flagErrs, total);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Twice the time all cases need
  initial begin
    #(NUM_CASES * CASE_BUDGET * CLK_PERIOD * 2);
    $display("Watchdog expired before the last case completed, the run is hung");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsConsts.svh"

module decodeStage (
  input wire CLK,
  input wire RST_X,
  input wire stall,
  input wire pipePkg::ifId_t ifId,
  input wire pipePkg::redirect_t redirect,
  input wire pipePkg::wbBus_t wb,
  output logic hold,
  output pipePkg::idEx_t idEx
);
  import isaPkg::*;

  opcode_t opcode;
  funct_t funct;
  regIdx_t rs;
  regIdx_t rt;
  regIdx_t rd; // R-format only
  regIdx_t dest;
  imm_t imm;
  word_t immExt;
  word_t rsVal;
  word_t rtVal;
  addr_t target;
  logic isAdd;
  logic isAddi;
  logic isBeq;
  logic isBne;
  logic isLw;
  logic isSw;
  logic known; // One of the six supported words
  logic usesRt; // rt is a source, not a dest

  assign opcode = ifId.instr[31:26];
  assign rs = ifId.instr[25:21];
  assign rt = ifId.instr[20:16];
  assign rd = ifId.instr[15:11];
  assign imm = ifId.instr[15:0];
  assign funct = ifId.instr[5:0];

  assign isAdd = (opcode == '0) && (funct == `FN_ADD);
  assign isAddi = opcode == `OP_ADDI;
  assign isBeq = opcode == `OP_BEQ;
  assign isBne = opcode == `OP_BNE;
  assign isLw = opcode == `OP_LW;
  assign isSw = opcode == `OP_SW;
  assign known = isAdd || isAddi || isBeq || isBne || isLw || isSw; // Anything else is a bubble
  assign usesRt = isAdd || isBeq || isBne || isSw;

  always_comb begin
    if (isAdd) begin
      dest = rd;
    end else if (isAddi || isLw) begin
      dest = rt;
    end else begin
      dest = '0; // Branches and stores write nothing
    end
  end

  assign immExt = {{(`WORD_W - 16){imm[15]}}, imm};
  assign target = ifId.pc + `PC_STEP + {immExt[`ADDR_W-3:0], 2'b00}; // Word offset from PC plus 4

  regFile i_regFile (
    .CLK(CLK),
    .rsIdx(rs),
    .rtIdx(rt),
    .rsVal(rsVal),
    .rtVal(rtVal),
    .wb(wb),
    .stall(stall)
  );

  // Load in EX feeds this word, its data is not ready until WB
  assign hold = ifId.valid && known && idEx.valid && idEx.isLw && (idEx.dest != '0)
    && ((rs == idEx.dest) || (usesRt && (rt == idEx.dest)));

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      idEx.valid <= 1'b0;
    end else if (!stall) begin
      idEx.valid <= ifId.valid && known && !hold && !redirect.taken; // Bubble on hold or flush
    end
    if (!stall) begin
      idEx.isAdd <= isAdd;
      idEx.isAddi <= isAddi;
      idEx.isBeq <= isBeq;
      idEx.isBne <= isBne;
      idEx.isLw <= isLw;
      idEx.isSw <= isSw;
      idEx.rs <= rs;
      idEx.rt <= rt;
      idEx.dest <= dest;
      idEx.rsVal <= rsVal;
      idEx.rtVal <= rtVal;
      idEx.immExt <= immExt;
      idEx.target <= target;
    end
  end

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input wire CLK,
  input wire RST_X,
  input wire stall,
  input wire pipePkg::idEx_t idEx,
  input wire pipePkg::wbBus_t wb,
  output pipePkg::redirect_t redirect,
  output pipePkg::exMem_t exMem
);
  import isaPkg::*;
  import pipePkg::*;

  word_t rsFwd;
  word_t rtFwd;
  word_t opB; // Second adder input
  word_t sum;
  logic useImm;
  logic writes; // Instruction has a register result
  logic taken;

  // Newest producer first, a load in MEM is covered by the ID hold
  function automatic word_t forward(regIdx_t src, word_t decoded, exMem_t mem, wbBus_t back);
    if (mem.valid && !mem.isLw && (mem.dest != '0) && (mem.dest == src)) begin
      return mem.result;
    end else if (back.valid && (back.dest != '0) && (back.dest == src)) begin
      return back.value;
    end else begin
      return decoded;
    end
  endfunction

  assign rsFwd = forward(idEx.rs, idEx.rsVal, exMem, wb);
  assign rtFwd = forward(idEx.rt, idEx.rtVal, exMem, wb);

  assign useImm = idEx.isAddi || idEx.isLw || idEx.isSw;
  assign opB = useImm ? idEx.immExt : rtFwd;
  assign sum = rsFwd + opB; // Also the load and store address

  assign taken = idEx.valid
    && ((idEx.isBeq && (rsFwd == rtFwd)) || (idEx.isBne && (rsFwd != rtFwd)));
  assign redirect = '{taken: taken, target: idEx.target}; // Not-taken is the prediction

  assign writes = idEx.valid && (idEx.isAdd || idEx.isAddi || idEx.isLw);

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      exMem.valid <= 1'b0;
    end else if (!stall) begin
      exMem.valid <= idEx.valid;
    end
    if (!stall) begin
      exMem.isLw <= idEx.isLw;
      exMem.isSw <= idEx.isSw;
      exMem.dest <= writes ? idEx.dest : '0;
      exMem.result <= sum;
      exMem.storeData <= rtFwd; // Forwarded, so a just-written value is stored
    end
  end

endmodule

`default_nettype wire

/* verilog/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsConsts.svh"

module fetchStage (
  input wire CLK,
  input wire RST_X,
  input wire stall,
  input wire hold,
  input wire pipePkg::redirect_t redirect,
  output isaPkg::addr_t iAddr,
  input wire isaPkg::word_t iData,
  output pipePkg::ifId_t ifId
);
  import isaPkg::*;

  addr_t pc; // Address fetched this cycle
  addr_t nextPc;

  assign iAddr = pc; // Memory answers in the same cycle

  always_comb begin
    if (redirect.taken) begin
      nextPc = redirect.target; // Taken branch from EX wins
    end else if (hold) begin
      nextPc = pc; // Refetch behind the load bubble
    end else begin
      nextPc = pc + `PC_STEP;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      pc <= `PC_RESET;
      ifId.valid <= 1'b0;
    end else if (!stall) begin
      pc <= nextPc;
      if (redirect.taken) begin
        ifId.valid <= 1'b0; // Squash wrong-path word
      end else if (!hold) begin
        ifId.valid <= 1'b1;
      end
    end
    if (!stall && !hold) begin
      ifId.instr <= iData;
      ifId.pc <= pc;
    end
  end

endmodule

`default_nettype wire

/* verilog/isaPkg.sv */
`default_nettype none
`include "mipsConsts.svh"

package isaPkg;

  // Data value, also the raw instruction word
  typedef logic [`WORD_W-1:0] word_t;

  // Byte address, low two bits zero for word accesses
  typedef logic [`ADDR_W-1:0] addr_t;

  typedef logic [`REG_W-1:0] regIdx_t; // Register number

  typedef logic [5:0] opcode_t; // Bits 31 to 26
  typedef logic [5:0] funct_t; // R-format bits 5 to 0

  typedef logic [15:0] imm_t; // I-format immediate before extension

endpackage

`default_nettype wire

/* verilog/memStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memStage (
  input wire CLK,
  input wire RST_X,
  input wire stall,
  input wire pipePkg::exMem_t exMem,
  output isaPkg::addr_t dAddr,
  output isaPkg::word_t dWData,
  input wire isaPkg::word_t dRData,
  output logic dWrite,
  output logic dRead,
  output pipePkg::wbBus_t wb
);
  import isaPkg::*;
  import pipePkg::*;

  memWb_t memWb;

  assign dAddr = addr_t'(exMem.result); // Low bits of the sum
  assign dWData = exMem.storeData;
  assign dWrite = exMem.valid && exMem.isSw && !stall; // No strobe while frozen
  assign dRead = exMem.valid && exMem.isLw && !stall;

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      memWb.valid <= 1'b0;
    end else if (!stall) begin
      memWb.valid <= exMem.valid;
    end
    if (!stall) begin
      memWb.isLw <= exMem.isLw;
      memWb.dest <= exMem.dest;
      memWb.result <= exMem.result;
    end
  end

  // Load data is registered by the memory and shows up here
  assign wb = '{
    valid: memWb.valid,
    dest: memWb.dest,
    value: memWb.isLw ? dRData : memWb.result
  };

endmodule

`default_nettype wire

/* verilog/mipsConsts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define WORD_W 32 // Data and instruction word
`define ADDR_W 12 // Byte address into either memory
`define REG_W 5 // 32 architectural registers

// Primary opcodes, R-format uses opcode zero
`define OP_ADDI 6'h08
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_LW 6'h23
`define OP_SW 6'h2b

`define FN_ADD 6'h20 // R-format add

`define PC_RESET 12'h000 // First fetch address
`define PC_STEP 12'd4 // One word per fetch

`endif

/* verilog/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
  input wire CLK,
  input wire RST_X,
  input wire stall,
  output isaPkg::addr_t iAddr,
  input wire isaPkg::word_t iData,
  output isaPkg::addr_t dAddr,
  output isaPkg::word_t dWData,
  input wire isaPkg::word_t dRData,
  output logic dWrite,
  output logic dRead
);
  import pipePkg::*;

  ifId_t ifId;
  idEx_t idEx;
  exMem_t exMem;
  wbBus_t wb; // To register file and EX forwarding
  redirect_t redirect; // From EX to IF and ID
  logic hold; // Load-use bubble request

  fetchStage i_fetchStage (
    .CLK(CLK),
    .RST_X(RST_X),
    .stall(stall),
    .hold(hold),
    .redirect(redirect),
    .iAddr(iAddr),
    .iData(iData),
    .ifId(ifId)
  );

  decodeStage i_decodeStage (
    .CLK(CLK),
    .RST_X(RST_X),
    .stall(stall),
    .ifId(ifId),
    .redirect(redirect),
    .wb(wb),
    .hold(hold),
    .idEx(idEx)
  );

  executeStage i_executeStage (
    .CLK(CLK),
    .RST_X(RST_X),
    .stall(stall),
    .idEx(idEx),
    .wb(wb),
    .redirect(redirect),
    .exMem(exMem)
  );

  memStage i_memStage (
    .CLK(CLK),
    .RST_X(RST_X),
    .stall(stall),
    .exMem(exMem),
    .dAddr(dAddr),
    .dWData(dWData),
    .dRData(dRData),
    .dWrite(dWrite),
    .dRead(dRead),
    .wb(wb)
  );

endmodule

`default_nettype wire

/* verilog/pipePkg.sv */
`default_nettype none
`include "mipsConsts.svh"

package pipePkg;
  import isaPkg::*;

  typedef struct packed {
    logic valid;
    word_t instr; // Fetched word
    addr_t pc; // Its address
  } ifId_t;

  typedef struct packed {
    logic valid;
    logic isAdd;
    logic isAddi;
    logic isBeq;
    logic isBne;
    logic isLw;
    logic isSw;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t dest; // Zero when nothing is written
    word_t rsVal; // Register file read, write-through applied
    word_t rtVal;
    word_t immExt; // Sign-extended immediate
    addr_t target; // Branch target, PC plus 4 plus offset
  } idEx_t;

  typedef struct packed {
    logic valid;
    logic isLw;
    logic isSw;
    regIdx_t dest; // Zero means no write
    word_t result; // ALU sum or memory address
    word_t storeData;
  } exMem_t;

  typedef struct packed {
    logic valid;
    logic isLw; // Pick the data port instead of result
    regIdx_t dest;
    word_t result;
  } memWb_t;

  // Architectural write and the last forwarding source
  typedef struct packed {
    logic valid;
    regIdx_t dest;
    word_t value;
  } wbBus_t;

  typedef struct packed {
    logic taken; // Branch in EX is taken
    addr_t target;
  } redirect_t;

endpackage

`default_nettype wire

/* verilog/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input wire CLK,
  input wire isaPkg::regIdx_t rsIdx,
  input wire isaPkg::regIdx_t rtIdx,
  output isaPkg::word_t rsVal,
  output isaPkg::word_t rtVal,
  input wire pipePkg::wbBus_t wb,
  input wire stall
);
  import isaPkg::*;

  word_t regs [32]; // Entry 0 never written
  logic wrEn;
  logic rsHit; // WB writes the register being read
  logic rtHit;

  assign wrEn = wb.valid && (wb.dest != '0) && !stall; // Frozen WB must not write twice

  always_ff @(posedge CLK) begin
    if (wrEn) begin
      regs[wb.dest] <= wb.value;
    end
  end

  // Write-through so ID sees the value landing this cycle
  assign rsHit = wb.valid && (wb.dest != '0) && (wb.dest == rsIdx);
  assign rtHit = wb.valid && (wb.dest != '0) && (wb.dest == rtIdx);

  assign rsVal = (rsIdx == '0) ? '0 : (rsHit ? wb.value : regs[rsIdx]);
  assign rtVal = (rtIdx == '0) ? '0 : (rtHit ? wb.value : regs[rtIdx]);

endmodule

`default_nettype wire
